/* logic/tart_settings.svh */
`ifndef TART_SETTINGS_SVH
`define TART_SETTINGS_SVH

// ----------------------------------------
// Sizes and rates
// ----------------------------------------
`define TART_ANTENNAE      24   // Antenna bits per sample
`define TART_TMUX_RATE     12   // Cycles between capture strobes
`define TART_BUFFER_DEPTH  32   // Raw buffer entries
`define TART_BUFFER_BITS   5    // Raw buffer address width
`define TART_RESET_TICKS   4    // Soft reset length in cycles

// ----------------------------------------
// Device field of the bus address
// ----------------------------------------
`define TART_DEV_CAP  2'd0   // Capture unit
`define TART_DEV_ACQ  2'd1   // Acquisition unit
`define TART_DEV_DSP  2'd2   // Empty correlator slot
`define TART_DEV_SYS  2'd3   // System control

`endif

/* logic/tart_pkg.sv */
`include "tart_settings.svh"

package tart_pkg;

    // ----------------------------------------
    // Bus types
    // ----------------------------------------
    typedef logic [7:0] bus_data_t;   // Byte-wide register bus
    typedef logic [3:0] bus_addr_t;   // [3:2] device, [1:0] register

    // Register offset within a device
    typedef enum logic [1:0] {
        REG_0 = 2'd0,
        REG_1 = 2'd1,
        REG_2 = 2'd2,
        REG_3 = 2'd3
    } reg_sel_e;

    // ----------------------------------------
    // Sample path types
    // ----------------------------------------
    typedef logic [`TART_ANTENNAE-1:0]    sample_t;     // One bit per antenna
    typedef logic [`TART_BUFFER_BITS-1:0] buf_addr_t;   // Raw buffer index

    // Acquisition FSM
    typedef enum logic [1:0] {
        ACQ_IDLE = 2'd0,   // Nothing captured
        ACQ_FILL = 2'd1,   // Writing samples at each strobe
        ACQ_FULL = 2'd2    // Buffer complete and ready to stream
    } acq_state_e;

endpackage

/* logic/tart_raw_buffer.sv */
`timescale 1ns/1ps
`include "tart_settings.svh"

module tart_raw_buffer (
    input  logic                clock_b,
    input  logic                we_i,
    input  tart_pkg::buf_addr_t addr_i,   // Shared by writes and reads
    input  tart_pkg::sample_t   data_i,
    output tart_pkg::sample_t   data_o    // One cycle after addr_i
);

    // ----------------------------------------
    // Sample storage
    // ----------------------------------------
    tart_pkg::sample_t mem [`TART_BUFFER_DEPTH];

    always_ff @(posedge clock_b) begin
        if (we_i)
            mem[addr_i] <= data_i;
        data_o <= mem[addr_i];   // Registered read returns old data on a write
    end

endmodule

/* logic/tart_capture.sv */
`timescale 1ns/1ps
`include "tart_settings.svh"

module tart_capture (
    input  logic                clock_b,
    input  logic                rst_n_i,
    // Register bus
    input  logic                stb_i,
    input  logic                we_i,
    input  tart_pkg::reg_sel_e  reg_i,
    input  tart_pkg::bus_data_t dat_i,
    output logic                ack_o,
    output tart_pkg::bus_data_t dat_o,
    // Antenna side
    input  tart_pkg::sample_t   antenna_i,
    output logic                enabled_o,
    output logic                debug_o,
    output logic                strobe_o,   // New sample on signal_o
    output tart_pkg::sample_t   signal_o
);
    import tart_pkg::*;

    localparam int TMUX_BITS = $clog2(`TART_TMUX_RATE);

    logic                 enabled_q, debug_q;
    logic [TMUX_BITS-1:0] tmux_cnt;     // Sample-rate divider
    logic                 tmux_wrap;
    sample_t              fake_cnt;     // Debug sample counter
    sample_t              signal_q;
    logic                 strobe_q;
    logic                 ctrl_wr;

    assign ctrl_wr   = stb_i && we_i && (reg_i == REG_0);
    assign tmux_wrap = (tmux_cnt == TMUX_BITS'(`TART_TMUX_RATE - 1));

    // ----------------------------------------
    // Control register and strobe divider
    // ----------------------------------------
    always_ff @(posedge clock_b) begin
        if (!rst_n_i) begin
            enabled_q <= 1'b0;
            debug_q   <= 1'b0;
            tmux_cnt  <= '0;
            strobe_q  <= 1'b0;
            fake_cnt  <= '0;
        end else begin
            if (ctrl_wr) begin
                enabled_q <= dat_i[0];
                debug_q   <= dat_i[1];
            end
            // Divider only runs while enabled
            if (!enabled_q || tmux_wrap)
                tmux_cnt <= '0;
            else
                tmux_cnt <= tmux_cnt + 1'b1;
            strobe_q <= enabled_q && tmux_wrap;
            // Counter restarts when debug is switched on
            if (ctrl_wr && dat_i[1] && !debug_q)
                fake_cnt <= '0;
            else if (enabled_q && tmux_wrap)
                fake_cnt <= fake_cnt + 1'b1;
        end
    end

    // Sample latched in step with the strobe
    always_ff @(posedge clock_b) begin
        if (enabled_q && tmux_wrap)
            signal_q <= debug_q ? fake_cnt : antenna_i;
    end

    // ----------------------------------------
    // Bus reads
    // ----------------------------------------
    always_ff @(posedge clock_b) begin
        if (!rst_n_i)
            ack_o <= 1'b0;
        else
            ack_o <= stb_i;
    end

    always_ff @(posedge clock_b) begin
        case (reg_i)
            REG_0:   dat_o <= {6'b000000, debug_q, enabled_q};
            REG_1:   dat_o <= signal_q[7:0];     // Low byte
            REG_2:   dat_o <= signal_q[15:8];
            default: dat_o <= signal_q[23:16];   // High byte
        endcase
    end

    assign enabled_o = enabled_q;
    assign debug_o   = debug_q;
    assign strobe_o  = strobe_q;
    assign signal_o  = signal_q;

endmodule

/* logic/tart_acquire.sv */
`timescale 1ns/1ps
`include "tart_settings.svh"

module tart_acquire (
    input  logic                 clock_b,
    input  logic                 rst_n_i,
    // Register bus
    input  logic                 stb_i,
    input  logic                 we_i,
    input  tart_pkg::reg_sel_e   reg_i,
    input  tart_pkg::bus_data_t  dat_i,
    output logic                 ack_o,
    output tart_pkg::bus_data_t  dat_o,
    // From the capture unit
    input  logic                 strobe_i,
    input  tart_pkg::sample_t    signal_i,
    // Status
    output logic                 enabled_o,
    output tart_pkg::acq_state_e state_o
);
    import tart_pkg::*;

    localparam int CNT_BITS = `TART_BUFFER_BITS + 1;   // Must hold the full depth

    acq_state_e          state_q;
    logic                enabled_q;
    logic [CNT_BITS-1:0] count_q;       // Fill count and write address
    buf_addr_t           rd_ptr_q;      // Entry being streamed
    buf_addr_t           rd_ptr_nxt;
    logic [1:0]          byte_q;        // 0 low, 1 middle, 2 high
    logic                ctrl_wr;
    logic                stream_rd;
    logic                rd_wrap;       // Last byte of the entry
    logic                buf_we;
    buf_addr_t           buf_addr;
    sample_t             buf_rdata;
    bus_data_t           stream_byte;

    assign ctrl_wr   = stb_i && we_i && (reg_i == REG_0);
    assign stream_rd = stb_i && !we_i && (reg_i == REG_2) && (state_q == ACQ_FULL);
    assign rd_wrap   = (byte_q == 2'd2);

    // ----------------------------------------
    // Buffer port sharing
    // ----------------------------------------
    // Next entry is addressed early so it is ready for back-to-back reads
    assign rd_ptr_nxt = (stream_rd && rd_wrap) ? rd_ptr_q + 1'b1 : rd_ptr_q;
    assign buf_we     = strobe_i && (state_q == ACQ_FILL);
    assign buf_addr   = (state_q == ACQ_FILL) ? count_q[`TART_BUFFER_BITS-1:0] : rd_ptr_nxt;

    tart_raw_buffer u_raw_buffer (
        .clock_b (clock_b),
        .we_i    (buf_we),
        .addr_i  (buf_addr),
        .data_i  (signal_i),
        .data_o  (buf_rdata)
    );

    // ----------------------------------------
    // FSM and pointers
    // ----------------------------------------
    always_ff @(posedge clock_b) begin
        if (!rst_n_i) begin
            state_q   <= ACQ_IDLE;
            enabled_q <= 1'b0;
            count_q   <= '0;
            rd_ptr_q  <= '0;
            byte_q    <= 2'd0;
            ack_o     <= 1'b0;
        end else begin
            ack_o <= stb_i;
            if (ctrl_wr) begin
                enabled_q <= dat_i[0];
                if (dat_i[0]) begin     // Start a new fill
                    state_q  <= ACQ_FILL;
                    count_q  <= '0;
                    rd_ptr_q <= '0;
                    byte_q   <= 2'd0;
                end else begin
                    state_q  <= ACQ_IDLE;   // Abort
                end
            end else begin
                if (buf_we) begin
                    count_q <= count_q + 1'b1;
                    if (count_q == CNT_BITS'(`TART_BUFFER_DEPTH - 1))
                        state_q <= ACQ_FULL;
                end
                if (stream_rd) begin
                    byte_q   <= rd_wrap ? 2'd0 : byte_q + 1'b1;
                    rd_ptr_q <= rd_ptr_nxt;   // Wraps after the last entry
                end
            end
        end
    end

    // Byte of the prefetched entry
    always_comb begin
        case (byte_q)
            2'd0:    stream_byte = buf_rdata[7:0];
            2'd1:    stream_byte = buf_rdata[15:8];
            default: stream_byte = buf_rdata[23:16];
        endcase
    end

    // ----------------------------------------
    // Bus reads
    // ----------------------------------------
    always_ff @(posedge clock_b) begin
        case (reg_i)
            REG_0:   dat_o <= {7'b0000000, enabled_q};
            REG_1:   dat_o <= 8'(count_q);
            REG_2:   dat_o <= (state_q == ACQ_FULL) ? stream_byte : 8'h00;
            default: dat_o <= {6'b000000, state_q};
        endcase
    end

    assign enabled_o = enabled_q;
    assign state_o   = state_q;

endmodule

/* logic/tart_control.sv */
`timescale 1ns/1ps
`include "tart_settings.svh"

module tart_control (
    input  logic                 clock_b,
    input  logic                 rst_n_i,          // External reset
    // Register bus
    input  logic                 stb_i,
    input  logic                 we_i,
    input  tart_pkg::reg_sel_e   reg_i,
    input  tart_pkg::bus_data_t  dat_i,
    output logic                 ack_o,
    output tart_pkg::bus_data_t  dat_o,
    // Status inputs
    input  logic                 cap_enabled_i,
    input  logic                 cap_debug_i,
    input  logic                 acq_enabled_i,
    input  tart_pkg::acq_state_e acq_state_i,
    // Reset for the decoder and peripherals
    output logic                 periph_rst_n_o
);
    import tart_pkg::*;

    localparam int TICK_BITS = $clog2(`TART_RESET_TICKS + 1);

    logic [TICK_BITS-1:0] rst_cnt_q;   // Soft reset cycles left
    logic                 rst_wr;
    bus_data_t            status;

    // Any value written to the reset register triggers it
    assign rst_wr = stb_i && we_i && (reg_i == REG_1);

    // Status byte layout
    assign status = {3'b000, acq_state_i, acq_enabled_i, cap_debug_i, cap_enabled_i};

    // ----------------------------------------
    // Soft reset timer
    // ----------------------------------------
    always_ff @(posedge clock_b) begin
        if (!rst_n_i) begin
            rst_cnt_q <= '0;
            ack_o     <= 1'b0;
        end else begin
            ack_o <= stb_i;
            if (rst_wr)
                rst_cnt_q <= TICK_BITS'(`TART_RESET_TICKS);
            else if (rst_cnt_q != '0)
                rst_cnt_q <= rst_cnt_q - 1'b1;
        end
    end

    // Low during external reset and while the timer runs
    assign periph_rst_n_o = rst_n_i && (rst_cnt_q == '0);

    // Only the status register reads back
    always_ff @(posedge clock_b) begin
        dat_o <= (reg_i == REG_0) ? status : 8'h00;
    end

endmodule

/* logic/tart_wishbone.sv */
`timescale 1ns/1ps
`include "tart_settings.svh"

module tart_wishbone (
    input  logic                clock_b,
    input  logic                rst_n_i,
    // Host side
    input  logic                cyc_i,
    input  logic                stb_i,
    input  logic                we_i,
    input  tart_pkg::bus_addr_t adr_i,
    input  tart_pkg::bus_data_t dat_i,
    output logic                ack_o,
    output tart_pkg::bus_data_t dat_o,
    // Peripheral returns
    input  logic                cap_ack_i,
    input  tart_pkg::bus_data_t cap_dat_i,
    input  logic                acq_ack_i,
    input  tart_pkg::bus_data_t acq_dat_i,
    input  logic                sys_ack_i,
    input  tart_pkg::bus_data_t sys_dat_i,
    // Peripheral requests
    output logic                cap_stb_o,
    output logic                acq_stb_o,
    output logic                sys_stb_o,
    output logic                we_o,
    output tart_pkg::reg_sel_e  reg_o,
    output tart_pkg::bus_data_t wdat_o
);
    import tart_pkg::*;

    logic       xfer;        // One transfer this cycle
    logic [1:0] dev;         // Device field
    logic [1:0] dev_q;       // Device of the previous strobe
    logic       dsp_ack_q;   // Ack for the empty DSP slot

    assign xfer = cyc_i & stb_i;
    assign dev  = adr_i[3:2];

    // ----------------------------------------
    // Strobe routing
    // ----------------------------------------
    assign cap_stb_o = xfer && (dev == `TART_DEV_CAP);
    assign acq_stb_o = xfer && (dev == `TART_DEV_ACQ);
    assign sys_stb_o = xfer && (dev == `TART_DEV_SYS);

    // Shared by all peripherals
    assign we_o   = we_i;
    assign reg_o  = reg_sel_e'(adr_i[1:0]);
    assign wdat_o = dat_i;

    always_ff @(posedge clock_b) begin
        if (!rst_n_i) begin
            dsp_ack_q <= 1'b0;
            dev_q     <= `TART_DEV_CAP;
        end else begin
            dsp_ack_q <= xfer && (dev == `TART_DEV_DSP);
            dev_q     <= dev;   // Lines up with the ack one cycle on
        end
    end

    // ----------------------------------------
    // Return path
    // ----------------------------------------
    // Only one device acks in a given cycle
    assign ack_o = cap_ack_i | acq_ack_i | sys_ack_i | dsp_ack_q;

    always_comb begin
        case (dev_q)
            `TART_DEV_CAP: dat_o = cap_dat_i;
            `TART_DEV_ACQ: dat_o = acq_dat_i;
            `TART_DEV_SYS: dat_o = sys_dat_i;
            default:       dat_o = '0;   // DSP slot
        endcase
    end

endmodule

/* logic/tart_top.sv */
`timescale 1ns/1ps

module tart_top (
    input  logic                clock_b,
    input  logic                rst_n_i,
    input  tart_pkg::sample_t   antenna_i,   // Raw antenna bits
    // Host register bus
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  logic                wb_we_i,
    input  tart_pkg::bus_addr_t wb_adr_i,
    input  tart_pkg::bus_data_t wb_dat_i,
    output logic                wb_ack_o,
    output tart_pkg::bus_data_t wb_dat_o
);
    import tart_pkg::*;

    // ----------------------------------------
    // Decoder to peripheral wires
    // ----------------------------------------
    logic       cap_stb, acq_stb, sys_stb;
    logic       bus_we;
    reg_sel_e   bus_reg;
    bus_data_t  bus_wdat;
    logic       cap_ack, acq_ack, sys_ack;
    bus_data_t  cap_dat, acq_dat, sys_dat;

    // Status and sample links
    logic       cap_enabled, cap_debug;
    logic       cap_strobe;
    sample_t    cap_signal;
    logic       acq_enabled;
    acq_state_e acq_state;
    logic       periph_rst_n;   // Soft reset from the control unit

    tart_wishbone u_wishbone (
        .clock_b   (clock_b),
        .rst_n_i   (periph_rst_n),
        .cyc_i     (wb_cyc_i),
        .stb_i     (wb_stb_i),
        .we_i      (wb_we_i),
        .adr_i     (wb_adr_i),
        .dat_i     (wb_dat_i),
        .ack_o     (wb_ack_o),
        .dat_o     (wb_dat_o),
        .cap_ack_i (cap_ack),
        .cap_dat_i (cap_dat),
        .acq_ack_i (acq_ack),
        .acq_dat_i (acq_dat),
        .sys_ack_i (sys_ack),
        .sys_dat_i (sys_dat),
        .cap_stb_o (cap_stb),
        .acq_stb_o (acq_stb),
        .sys_stb_o (sys_stb),
        .we_o      (bus_we),
        .reg_o     (bus_reg),
        .wdat_o    (bus_wdat)
    );

    // Antenna sampling
    tart_capture u_capture (
        .clock_b   (clock_b),
        .rst_n_i   (periph_rst_n),
        .stb_i     (cap_stb),
        .we_i      (bus_we),
        .reg_i     (bus_reg),
        .dat_i     (bus_wdat),
        .antenna_i (antenna_i),
        .ack_o     (cap_ack),
        .dat_o     (cap_dat),
        .enabled_o (cap_enabled),
        .debug_o   (cap_debug),
        .strobe_o  (cap_strobe),
        .signal_o  (cap_signal)
    );

    // Raw buffer fill and readback
    tart_acquire u_acquire (
        .clock_b   (clock_b),
        .rst_n_i   (periph_rst_n),
        .stb_i     (acq_stb),
        .we_i      (bus_we),
        .reg_i     (bus_reg),
        .dat_i     (bus_wdat),
        .strobe_i  (cap_strobe),
        .signal_i  (cap_signal),
        .ack_o     (acq_ack),
        .dat_o     (acq_dat),
        .enabled_o (acq_enabled),
        .state_o   (acq_state)
    );

    // Status and soft reset on the external reset only
    tart_control u_control (
        .clock_b        (clock_b),
        .rst_n_i        (rst_n_i),
        .stb_i          (sys_stb),
        .we_i           (bus_we),
        .reg_i          (bus_reg),
        .dat_i          (bus_wdat),
        .cap_enabled_i  (cap_enabled),
        .cap_debug_i    (cap_debug),
        .acq_enabled_i  (acq_enabled),
        .acq_state_i    (acq_state),
        .ack_o          (sys_ack),
        .dat_o          (sys_dat),
        .periph_rst_n_o (periph_rst_n)
    );

endmodule

/* sim/tart_tb.sv */
`timescale 1ns/1ps
`include "tart_settings.svh"

module tart_tb;
    import tart_pkg::*;

    // About 3 fills of 32 x 12 plus bus traffic and margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic      clock_b;
    logic      rst_n_i;
    sample_t   antenna_i;
    logic      wb_cyc_i, wb_stb_i, wb_we_i;
    bus_addr_t wb_adr_i;
    bus_data_t wb_dat_i;
    logic      wb_ack_o;
    bus_data_t wb_dat_o;

    logic [31:0] lfsr_q = 32'd86221;
    int          cycle_cnt = 0;

    tart_top tart_top_i (
        .clock_b   (clock_b),
        .rst_n_i   (rst_n_i),
        .antenna_i (antenna_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_ack_o  (wb_ack_o),
        .wb_dat_o  (wb_dat_o)
    );

    initial begin
        clock_b = 1'b0;
        forever #5 clock_b = ~clock_b;   // 10 ns period
    end

    // ----------------------------------------
    // Failure handling and checks
    // ----------------------------------------
    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    always @(posedge clock_b) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    task automatic check_byte(input string name, input bus_data_t got, input bus_data_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_state(input string name, input acq_state_e got, input acq_state_e exp);
        if (got !== exp) begin
            $display("Error at %0t: %s = %s, expected %s", $time, name, got.name(), exp.name());
            abort_run();
        end
    endtask

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // ----------------------------------------
    // Random bits
    // ----------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ 32'h80200003;   // Galois taps
        else
            return state >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic random_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            value  = {value[30:0], lfsr_q[0]};
        end
    endtask

    // ----------------------------------------
    // Bus access
    // ----------------------------------------
    // Ack must follow the strobe by exactly one cycle
    task automatic wait_ack();
        @(negedge clock_b);
        if (!wb_ack_o) begin
            $display("The bus gave no ack one cycle after the strobe at %0t", $time);
            abort_run();
        end
    endtask

    task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
        @(posedge clock_b);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= 1'b1;
        wb_adr_i <= addr;
        wb_dat_i <= data;
        @(posedge clock_b);
        wb_cyc_i <= 1'b0;   // Single transfer
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        wait_ack();
    endtask

    task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
        @(posedge clock_b);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= 1'b0;
        wb_adr_i <= addr;
        @(posedge clock_b);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wait_ack();
        data = wb_dat_o;    // Valid with the ack
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    initial begin
        logic [31:0] bits;
        bus_data_t   rd, lo, mid, hi, first_byte;
        logic        cap_en_m, cap_dbg_m;   // Model of capture control
        sample_t     entry, prev;
        acq_state_e  st;

        rst_n_i   = 1'b0;
        antenna_i = '0;
        wb_cyc_i  = 1'b0;
        wb_stb_i  = 1'b0;
        wb_we_i   = 1'b0;
        wb_adr_i  = '0;
        wb_dat_i  = '0;
        cap_en_m  = 1'b0;
        cap_dbg_m = 1'b0;
        prev      = '0;
        first_byte = '0;
        repeat (16) @(posedge clock_b);
        rst_n_i <= 1'b1;

        // Reset defaults
        bus_read(4'd0, rd);
        check_byte("wb_dat_o (capture control)", rd, 8'h00);
        bus_read(4'd4, rd);
        check_byte("wb_dat_o (acquisition control)", rd, 8'h00);
        bus_read(4'd5, rd);
        check_byte("wb_dat_o (fill count)", rd, 8'h00);
        bus_read(4'd12, rd);
        check_byte("wb_dat_o (status)", rd, 8'h00);
        for (int a = 8; a < 12; a++) begin
            bus_read(bus_addr_t'(a), rd);
            check_byte("wb_dat_o (DSP slot)", rd, 8'h00);
        end
        bus_read(4'd7, rd);
        check_state("acquisition state", acq_state_e'(rd[1:0]), ACQ_IDLE);
        bus_read(4'd6, rd);
        check_byte("wb_dat_o (stream when idle)", rd, 8'h00);

        // Random control traffic
        for (int n = 0; n < 32; n++) begin
            random_bits(1, bits);
            if (bits[0]) begin
                random_bits(2, bits);
                rd = bus_data_t'(bits[1:0]);      // Register within the DSP slot
                random_bits(8, bits);
                bus_write({2'b10, rd[1:0]}, bits[7:0]);
                bus_read({2'b10, rd[1:0]}, rd);
                check_byte("wb_dat_o (DSP slot)", rd, 8'h00);
            end else begin
                random_bits(8, bits);
                bus_write(4'd0, bits[7:0]);
                cap_en_m  = bits[0];
                cap_dbg_m = bits[1];
                bus_read(4'd0, rd);
                check_byte("wb_dat_o (capture control)", rd, {6'b000000, cap_dbg_m, cap_en_m});
            end
            bus_read(4'd12, rd);
            check_byte("wb_dat_o (status)", rd, {6'b000000, cap_dbg_m, cap_en_m}); // Acq idle
        end

        // Antenna capture, no debug
        bus_write(4'd0, 8'h01);
        random_bits(24, bits);
        @(posedge clock_b);
        antenna_i <= sample_t'(bits);
        repeat (2 * `TART_TMUX_RATE) @(posedge clock_b);
        bus_read(4'd1, rd);
        check_byte("wb_dat_o (sample low)", rd, bits[7:0]);
        bus_read(4'd2, rd);
        check_byte("wb_dat_o (sample middle)", rd, bits[15:8]);
        bus_read(4'd3, rd);
        check_byte("wb_dat_o (sample high)", rd, bits[23:16]);

        // Stream reads during a fill
        bus_write(4'd4, 8'h01);
        bus_read(4'd7, rd);
        check_state("acquisition state", acq_state_e'(rd[1:0]), ACQ_FILL);
        repeat (3) begin
            bus_read(4'd6, rd);
            check_byte("wb_dat_o (stream during fill)", rd, 8'h00);
        end

        // Debug acquisition, counter samples
        bus_write(4'd0, 8'h03);
        bus_write(4'd4, 8'h01);   // Restart the fill
        st = ACQ_FILL;
        while (st != ACQ_FULL) begin
            bus_read(4'd7, rd);
            st = acq_state_e'(rd[1:0]);
        end
        bus_read(4'd5, rd);
        check_byte("wb_dat_o (fill count)", rd, 8'(`TART_BUFFER_DEPTH));
        // Capture and acquisition enabled, debug on, buffer full
        bus_read(4'd12, rd);
        check_byte("wb_dat_o (status)", rd, {3'b000, ACQ_FULL, 1'b1, 1'b1, 1'b1});
        for (int i = 0; i < `TART_BUFFER_DEPTH; i++) begin
            bus_read(4'd6, lo);
            bus_read(4'd6, mid);
            bus_read(4'd6, hi);
            entry = {hi, mid, lo};
            if (i == 0)
                first_byte = lo;
            else
                check_sample("stream entry", entry, sample_t'(prev + 1'b1));
            prev = entry;
        end
        bus_read(4'd6, rd);       // Wraps to the first entry
        check_byte("wb_dat_o (stream wrap)", rd, first_byte);

        // Soft reset
        random_bits(8, bits);
        bus_write(4'd13, bits[7:0]);
        repeat (8) @(posedge clock_b);
        bus_read(4'd0, rd);
        check_byte("wb_dat_o (capture control)", rd, 8'h00);
        bus_read(4'd4, rd);
        check_byte("wb_dat_o (acquisition control)", rd, 8'h00);
        bus_read(4'd7, rd);
        check_state("acquisition state", acq_state_e'(rd[1:0]), ACQ_IDLE);
        bus_read(4'd12, rd);
        check_byte("wb_dat_o (status)", rd, 8'h00);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* tart_top.f */
+incdir+logic
logic/tart_pkg.sv
logic/tart_raw_buffer.sv
logic/tart_capture.sv
logic/tart_acquire.sv
logic/tart_control.sv
logic/tart_wishbone.sv
logic/tart_top.sv
sim/tart_tb.sv

/* Makefile */
SRCS := $(filter-out +%,$(shell cat tart_top.f)) logic/tart_settings.svh

.PHONY: run clean

run: obj_dir/Vtart_tb
	@out=$$(obj_dir/Vtart_tb 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

obj_dir/V%: $(SRCS) tart_top.f
	verilator --binary --timing --timescale 1ns/1ps -f tart_top.f --top-module $*

clean:
	rm -rf obj_dir
